// ==== verilog/spi_types_pkg.sv ====
`default_nettype none

package spi_types_pkg;

	// payload and divider widths
	localparam int DATA_W    = 8;
	localparam int CLK_DIV_W = 16;

	// one byte on the wire
	typedef logic [DATA_W-1:0] data_byte_t;

	// half-period length in system clocks
	typedef logic [CLK_DIV_W-1:0] clk_div_t;

	// phase strobes from the byte controller to the datapath
	typedef struct packed {
		// capture the transmit byte
		logic load;
		// a low phase begins, put the next bit on mosi
		logic drive;
		// end of low phase, sclk rises and miso is taken
		logic sample;
		// end of high phase, sclk falls and shifters advance
		logic shift;
		// byte finished
		logic done;
	} spi_strobe_t;

endpackage : spi_types_pkg

`default_nettype wire

// ==== verilog/spi_ctrl_pkg.sv ====
`default_nettype none

package spi_ctrl_pkg;

	// bits moved in one transfer
	localparam int BITS_PER_BYTE = 8;

	// wide enough to hold the bit index
	localparam int BIT_CNT_W = 4;

	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

	// index of the final bit, msb first
	localparam bit_cnt_t LAST_BIT = bit_cnt_t'(BITS_PER_BYTE - 1);

	// one byte transfer, mode 0
	typedef enum logic [2:0] {
		// waiting for a request
		IDLE,
		// transmit byte is captured here
		READY,
		// serial clock low half
		DCLK_L,
		// serial clock high half
		DCLK_H,
		// last bit done, ack follows
		DONE
	} byte_state_e;

endpackage : spi_ctrl_pkg

`default_nettype wire

// ==== verilog/spi_byte_ctrl.sv ====
`default_nettype none

module spi_byte_ctrl
	import spi_types_pkg::*;
	import spi_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	// host request level
	input  logic        i_wr_req,

	// terminal count from the clock generator
	input  logic        i_half_end,

	output logic        o_run,
	output spi_strobe_t o_strobe
);

	byte_state_e state;
	byte_state_e state_d;
	bit_cnt_t    bit_cnt;

	logic low_end;
	logic high_end;
	logic last_bit;
	logic done_q;

	assign low_end  = (state == DCLK_L) && i_half_end;
	assign high_end = (state == DCLK_H) && i_half_end;
	assign last_bit = (bit_cnt == LAST_BIT);

	// half-period counter only runs inside the bit phases
	assign o_run = (state == DCLK_L) || (state == DCLK_H);

	always_comb begin
		state_d = state;
		case (state)
			IDLE: begin
				if (i_wr_req) begin
					state_d = READY;
				end
			end
			READY: begin
				state_d = DCLK_L;
			end
			DCLK_L: begin
				if (i_half_end) begin
					state_d = DCLK_H;
				end
			end
			DCLK_H: begin
				if (i_half_end) begin
					state_d = last_bit ? DONE : DCLK_L;
				end
			end
			DONE: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_d;
		end
	end

	// counts completed high phases
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (state == IDLE) begin
			bit_cnt <= '0;
		end else if (high_end) begin
			bit_cnt <= bit_cnt + bit_cnt_t'(1);
		end
	end

	// ack comes one cycle after DONE, doubles as the done strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done_q <= 1'b0;
		end else begin
			done_q <= (state == DONE);
		end
	end

	always_comb begin
		o_strobe        = '0;
		o_strobe.load   = (state == READY);
		// first low phase, then every low phase after a non-final bit
		o_strobe.drive  = (state == READY) || (high_end && !last_bit);
		o_strobe.sample = low_end;
		o_strobe.shift  = high_end;
		o_strobe.done   = done_q;
	end

endmodule : spi_byte_ctrl

`default_nettype wire

// ==== verilog/spi_sclk_gen.sv ====
`default_nettype none

module spi_sclk_gen
	import spi_types_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	// half-period length, at least 1
	input  clk_div_t    i_clk_div,

	input  logic        i_run,
	input  spi_strobe_t i_strobe,

	output logic        o_half_end,
	output logic        o_sclk
);

	clk_div_t half_cnt;
	clk_div_t last_cnt;

	assign last_cnt = i_clk_div - clk_div_t'(1);

	// single place where the terminal count is tested
	assign o_half_end = i_run && (half_cnt == last_cnt);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			half_cnt <= '0;
		end else if (!i_run || o_half_end) begin
			half_cnt <= '0;
		end else begin
			half_cnt <= half_cnt + clk_div_t'(1);
		end
	end

	// idles low for mode 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sclk <= 1'b0;
		end else if (i_strobe.sample) begin
			o_sclk <= 1'b1;
		end else if (i_strobe.shift) begin
			o_sclk <= 1'b0;
		end
	end

endmodule : spi_sclk_gen

`default_nettype wire

// ==== verilog/spi_shift_reg.sv ====
`default_nettype none

module spi_shift_reg
	import spi_types_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	input  spi_strobe_t i_strobe,
	input  data_byte_t  i_data_in,

	input  logic        i_miso,
	output logic        o_mosi,

	output data_byte_t  o_data_out
);

	data_byte_t tx_q;
	data_byte_t tx_d;
	data_byte_t rx_q;
	data_byte_t data_q;

	// next transmit word, also feeds mosi so a bit is on the pin a full phase early
	always_comb begin
		tx_d = tx_q;
		if (i_strobe.load) begin
			tx_d = i_data_in;
		end else if (i_strobe.shift) begin
			tx_d = tx_q << 1;
		end
	end

	always_ff @(posedge clk) begin
		tx_q <= tx_d;
	end

	// msb first
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mosi <= 1'b0;
		end else if (i_strobe.done) begin
			o_mosi <= 1'b0;
		end else if (i_strobe.drive) begin
			o_mosi <= tx_d[DATA_W-1];
		end
	end

	// miso enters at the lsb on each rising sclk
	always_ff @(posedge clk) begin
		if (i_strobe.load) begin
			rx_q <= '0;
		end else if (i_strobe.sample) begin
			rx_q <= {rx_q[DATA_W-2:0], i_miso};
		end
	end

	// received byte, held until the next transfer ends
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_q <= '0;
		end else if (i_strobe.done) begin
			data_q <= rx_q;
		end
	end

	// new byte already visible in the ack cycle
	assign o_data_out = i_strobe.done ? rx_q : data_q;

endmodule : spi_shift_reg

`default_nettype wire

// ==== verilog/spi_master_top.sv ====
`default_nettype none

module spi_master_top
	import spi_types_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// host side
	input  logic       i_cs_ctrl,
	input  clk_div_t   i_clk_div,
	input  logic       i_wr_req,
	output logic       o_wr_ack,
	input  data_byte_t i_data_in,
	output data_byte_t o_data_out,

	// spi pins
	output logic       o_spi_cs,
	output logic       o_spi_dclk,
	output logic       o_spi_mosi,
	input  logic       i_spi_miso
);

	logic        run;
	logic        half_end;
	spi_strobe_t strobe;

	// chip select is the host's level, not sequenced here
	assign o_spi_cs = i_cs_ctrl;

	assign o_wr_ack = strobe.done;

	spi_byte_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_wr_req   (i_wr_req),
		.i_half_end (half_end),
		.o_run      (run),
		.o_strobe   (strobe)
	);

	spi_sclk_gen u_sclk (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_clk_div  (i_clk_div),
		.i_run      (run),
		.i_strobe   (strobe),
		.o_half_end (half_end),
		.o_sclk     (o_spi_dclk)
	);

	spi_shift_reg u_shift (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_strobe   (strobe),
		.i_data_in  (i_data_in),
		.i_miso     (i_spi_miso),
		.o_mosi     (o_spi_mosi),
		.o_data_out (o_data_out)
	);

endmodule : spi_master_top

`default_nettype wire

// ==== test/spi_slave_model.sv ====
`default_nettype none

module spi_slave_model
	import spi_types_pkg::*;
	import spi_ctrl_pkg::*;
(
	// active low select from the master
	input  logic       i_cs_n,
	input  logic       i_sclk,
	input  logic       i_mosi,
	output logic       o_miso,

	// byte returned on the next transfer
	input  data_byte_t i_resp,

	// byte captured from mosi
	output data_byte_t o_rx
);

	timeunit 1ns;
	timeprecision 1ps;

	data_byte_t tx_sh;

	// mode 0: first bit valid at select, change on falling, capture on rising
	initial begin
		o_miso = 1'b0;
		o_rx   = '0;
		tx_sh  = '0;
		forever begin
			@(negedge i_cs_n);
			tx_sh  = i_resp;
			o_miso = tx_sh[DATA_W-1];
			o_rx   = '0;
			for (int i = 0; i < BITS_PER_BYTE; i++) begin
				@(posedge i_sclk);
				o_rx = {o_rx[DATA_W-2:0], i_mosi};
				@(negedge i_sclk);
				tx_sh  = tx_sh << 1;
				o_miso = tx_sh[DATA_W-1];
			end
		end
	end

endmodule : spi_slave_model

`default_nettype wire

// ==== test/tb_spi_master.sv ====
`default_nettype none

module tb_spi_master
	import spi_types_pkg::*;
	import spi_ctrl_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD      = 40;
	localparam int DRIVE_DLY       = 2;
	localparam int NUM_ROWS        = 6;
	localparam int WATCHDOG_MARGIN = 20;

	typedef struct packed {
		clk_div_t   div;
		data_byte_t tx;
		data_byte_t resp;
		// pulse the request again mid-transfer
		logic       re_req;
	} row_t;

	logic       clk;
	logic       rst_n;
	logic       cs_ctrl;
	clk_div_t   clk_div;
	logic       wr_req;
	logic       wr_ack;
	data_byte_t data_in;
	data_byte_t data_out;
	logic       spi_cs;
	logic       spi_dclk;
	logic       spi_mosi;
	logic       spi_miso;
	data_byte_t slave_resp;
	data_byte_t slave_rx;

	row_t tbl [NUM_ROWS];
	bit   table_built;
	int   seed = 32'h5dc9;
	int   n_checks;
	int   n_errors;

	// monitor state, updated on falling clk
	int   edge_cnt;
	int   ack_cnt;
	int   ack_edge;
	data_byte_t ack_data;
	logic dclk_prev;
	int   rise_edges [$];
	int   fall_edges [$];

	spi_master_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_cs_ctrl  (cs_ctrl),
		.i_clk_div  (clk_div),
		.i_wr_req   (wr_req),
		.o_wr_ack   (wr_ack),
		.i_data_in  (data_in),
		.o_data_out (data_out),
		.o_spi_cs   (spi_cs),
		.o_spi_dclk (spi_dclk),
		.o_spi_mosi (spi_mosi),
		.i_spi_miso (spi_miso)
	);

	spi_slave_model slave (
		.i_cs_n (spi_cs),
		.i_sclk (spi_dclk),
		.i_mosi (spi_mosi),
		.o_miso (spi_miso),
		.i_resp (slave_resp),
		.o_rx   (slave_rx)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		edge_cnt = edge_cnt + 1;
	end

	// outputs are stable mid-cycle
	always @(negedge clk) begin
		if (wr_ack) begin
			ack_cnt  = ack_cnt + 1;
			ack_edge = edge_cnt;
			ack_data = data_out;
		end
		if (spi_dclk && !dclk_prev) begin
			rise_edges.push_back(edge_cnt);
		end
		if (!spi_dclk && dclk_prev) begin
			fall_edges.push_back(edge_cnt);
		end
		dclk_prev = spi_dclk;
	end

	task automatic check_value(input string what, input int got, input int exp);
		n_checks = n_checks + 1;
		if (got !== exp) begin
			n_errors = n_errors + 1;
			$display("FAILED at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_idle_pins(input string where);
		check_value({where, ": sclk"}, int'(spi_dclk), 0);
		check_value({where, ": mosi"}, int'(spi_mosi), 0);
		check_value({where, ": ack"}, int'(wr_ack), 0);
	endtask

	task automatic set_cs(input logic level);
		cs_ctrl = level;
		#1;
		check_value("spi cs follows cs control", int'(spi_cs), int'(level));
	endtask

	task automatic build_table();
		int rnd;
		tbl[0] = '{div: 16'd1, tx: 8'hA5, resp: 8'h3C, re_req: 1'b0};
		tbl[1] = '{div: 16'd2, tx: 8'h00, resp: 8'hFF, re_req: 1'b0};
		tbl[2] = '{div: 16'd5, tx: 8'hFF, resp: 8'h00, re_req: 1'b1};
		tbl[3] = '{div: 16'd1, tx: 8'h00, resp: 8'h00, re_req: 1'b1};
		tbl[4] = '{div: 16'd2, tx: 8'h00, resp: 8'h00, re_req: 1'b0};
		tbl[5] = '{div: 16'd5, tx: 8'h00, resp: 8'h00, re_req: 1'b1};
		for (int i = 3; i < NUM_ROWS; i++) begin
			rnd = $random(seed);
			tbl[i].tx   = rnd[7:0];
			tbl[i].resp = rnd[15:8];
		end
	endtask

	task automatic run_row(input int r);
		row_t row;
		int   n;
		int   start_edge;
		int   acks_before;
		row = tbl[r];
		n   = int'(row.div);

		@(posedge clk);
		#DRIVE_DLY;
		clk_div    = row.div;
		data_in    = row.tx;
		slave_resp = row.resp;
		rise_edges.delete();
		fall_edges.delete();
		set_cs(1'b0);
		acks_before = ack_cnt;

		@(posedge clk);
		#DRIVE_DLY;
		wr_req     = 1'b1;
		start_edge = edge_cnt + 1;
		@(posedge clk);
		#DRIVE_DLY;
		wr_req = 1'b0;

		// busy controller must ignore this, new data too
		if (row.re_req) begin
			repeat (4 * n) @(posedge clk);
			#DRIVE_DLY;
			wr_req  = 1'b1;
			data_in = ~row.tx;
			@(posedge clk);
			#DRIVE_DLY;
			wr_req = 1'b0;
		end

		wait (ack_cnt != acks_before);
		check_value("ack edge after request", ack_edge - start_edge, 16 * n + 2);
		check_value("data_out at ack", int'(ack_data), int'(row.resp));
		check_value("byte seen by slave", int'(slave_rx), int'(row.tx));

		@(negedge clk);
		check_idle_pins("after transfer");
		repeat (3) @(negedge clk);
		check_idle_pins("idle gap");
		// received byte stays on the output between transfers
		check_value("data_out held after ack", int'(data_out), int'(row.resp));
		@(posedge clk);
		#DRIVE_DLY;
		check_value("acks per transfer", ack_cnt - acks_before, 1);

		// levels of exactly n cycles, low phase first
		check_value("sclk rising edges", rise_edges.size(), BITS_PER_BYTE);
		check_value("sclk falling edges", fall_edges.size(), BITS_PER_BYTE);
		for (int k = 0; k < BITS_PER_BYTE; k++) begin
			if (k < rise_edges.size()) begin
				check_value("sclk rise position", rise_edges[k] - start_edge,
					1 + n + 2 * k * n);
			end
			if (k < fall_edges.size()) begin
				check_value("sclk fall position", fall_edges[k] - start_edge,
					1 + 2 * n + 2 * k * n);
			end
		end
		set_cs(1'b1);
	endtask

	initial begin
		int limit;
		wait (table_built);
		limit = WATCHDOG_MARGIN;
		for (int i = 0; i < NUM_ROWS; i++) begin
			limit = limit + 16 * int'(tbl[i].div) + 10;
		end
		repeat (limit) @(posedge clk);
		$display("timeout: tests did not finish within %0d clock cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		rst_n       = 1'b0;
		cs_ctrl     = 1'b1;
		clk_div     = 16'd1;
		wr_req      = 1'b0;
		data_in     = '0;
		slave_resp  = '0;
		n_checks    = 0;
		n_errors    = 0;
		edge_cnt    = 0;
		ack_cnt     = 0;
		ack_edge    = 0;
		ack_data    = '0;
		dclk_prev   = 1'b0;
		table_built = 1'b0;
		build_table();
		table_built = 1'b1;

		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		@(negedge clk);
		check_idle_pins("after reset");
		check_value("data_out after reset", int'(data_out), 0);
		check_value("spi cs after reset", int'(spi_cs), int'(cs_ctrl));

		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule : tb_spi_master

`default_nettype wire

// ==== verilog.f ====
verilog/spi_types_pkg.sv
verilog/spi_ctrl_pkg.sv
verilog/spi_byte_ctrl.sv
verilog/spi_sclk_gen.sv
verilog/spi_shift_reg.sv
verilog/spi_master_top.sv
test/spi_slave_model.sv
test/tb_spi_master.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_spi_master
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the simulation output holds the pass message
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
